//--- testbench/lsu_cases.txt
// op f3 addr w_data exp_r_data exp_err, all hex, one access per line
// op 0 none 1 read 2 write, f3 is the RV64 funct3, exp_r_data is 0 unless read
2 3 00000000 8877665544332211 0000000000000000 0
1 3 00000000 0000000000000000 8877665544332211 0
2 0 00000003 123456789abcdeab 0000000000000000 0
2 1 00000006 000000000000c3f0 0000000000000000 0
1 3 00000000 0000000000000000 c3f06655ab332211 0
1 0 00000003 0000000000000000 ffffffffffffffab 0
1 4 00000003 0000000000000000 00000000000000ab 0
1 1 00000006 0000000000000000 ffffffffffffc3f0 0
1 5 00000006 0000000000000000 000000000000c3f0 0
1 2 00000004 0000000000000000 ffffffffc3f06655 0
1 6 00000004 0000000000000000 00000000c3f06655 0
1 2 00000000 0000000000000000 ffffffffab332211 0
1 1 00000007 0000000000000000 0000000000000000 0
1 2 00000005 0000000000000000 0000000000000000 0
2 2 00000006 0000000011111111 0000000000000000 0
2 1 0000000f 000000000000eeee 0000000000000000 0
1 3 00000000 0000000000000000 c3f06655ab332211 0
2 3 0000000c ffffffffffffffff 0000000000000000 0
2 2 0000000c 000000007fedcba9 0000000000000000 0
1 3 00000008 0000000000000000 7fedcba900000000 0
1 2 0000000c 0000000000000000 000000007fedcba9 0
2 3 00000200 0000000000000055 0000000000000000 1
1 3 00000200 0000000000000000 0000000000000000 1
1 4 000001ff 0000000000000000 0000000000000000 0
0 0 00000000 0000000000000000 0000000000000000 0

//--- compile.f
hw/lsu_pkg.sv
hw/axi_lite_pkg.sv
hw/lsu_data_align.sv
hw/lsu_axi_master.sv
hw/lsu_axi_lite.sv
hw/axi_lite_ram.sv
hw/lsu_subsystem.sv
testbench/lsu_assert.sv
testbench/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f compile.f \
    && ./obj_dir/Vtb_lsu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

//--- testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    localparam int MEM_WORDS   = 64;
    localparam int WAIT_CYCLES = 2;
    localparam int MEM_BYTES   = MEM_WORDS * 8;
    localparam int TIMEOUT     = 100;   // Cycles allowed per request
    localparam int FIELDS      = 6;     // op f3 addr w_data r_data err
    localparam int MAX_CASES   = 64;
    localparam int RAND_CASES  = 200;

    localparam logic [1:0] OP_NONE  = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;

    logic              AXI_ACLK;
    logic              AXI_ARESETN;
    lsu_pkg::lsu_req_t req;
    logic              done;
    lsu_pkg::xlen_t    r_data;
    logic              err;

    logic [63:0] case_mem [FIELDS*MAX_CASES];
    logic [7:0]  model_mem [MEM_BYTES];   // Byte view of the RAM
    int          done_count;
    int          issued;

    lsu_subsystem #(
        .MEM_WORDS  (MEM_WORDS),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_lsu_subsystem (
        .AXI_ACLK   (AXI_ACLK),
        .AXI_ARESETN(AXI_ARESETN),
        .req        (req),
        .done       (done),
        .r_data     (r_data),
        .err        (err)
    );

    always #20 AXI_ACLK = ~AXI_ACLK;

    // Done pulses as seen on rising edges
    always @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    function automatic int unsigned access_size(input logic [2:0] f3);
        return 32'd1 << f3[1:0];
    endfunction

    function automatic logic in_range(input lsu_pkg::addr_t addr);
        return addr < 32'(MEM_BYTES);
    endfunction

    // Whole access inside one 8-byte lane
    function automatic logic fits_lane(input logic [2:0] f3, input lsu_pkg::addr_t addr);
        return (32'(addr[2:0]) + access_size(f3)) <= 32'd8;
    endfunction

    // Reference memory, also applies stores
    task automatic model_access(
        input  logic [1:0]     op,
        input  logic [2:0]     f3,
        input  lsu_pkg::addr_t addr,
        input  lsu_pkg::xlen_t w_data,
        output lsu_pkg::xlen_t data,
        output logic           bad
    );
        int unsigned size;
        logic        ok;
        size = access_size(f3);
        ok   = in_range(addr) && fits_lane(f3, addr);
        data = '0;
        bad  = (op != OP_NONE) && !in_range(addr);
        if (op == OP_READ && ok) begin
            for (int i = 0; i < int'(size); i++) begin
                data[8*i +: 8] = model_mem[int'(addr) + i];
            end
            if (!f3[2] && size < 8 && data[8*size-1]) begin
                data = data | (64'hffff_ffff_ffff_ffff << (8*size)); // Sign fill
            end
        end
        if (op == OP_WRITE && ok) begin
            for (int i = 0; i < int'(size); i++) begin
                model_mem[int'(addr) + i] = w_data[8*i +: 8];
            end
        end
    endtask

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input lsu_pkg::xlen_t got, input lsu_pkg::xlen_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Entered on a falling edge, returns on the falling edge after done
    task automatic run_req(
        input logic [1:0]     op,
        input logic [2:0]     f3,
        input lsu_pkg::addr_t addr,
        input lsu_pkg::xlen_t w_data,
        input lsu_pkg::xlen_t exp_data,
        input logic           exp_err,
        input string          tag
    );
        int   cycles;
        logic seen;
        cycles     = 0;
        seen       = 1'b0;
        req.valid  = 1'b1;
        req.r_en   = (op == OP_READ);
        req.w_en   = (op == OP_WRITE);
        req.funct3 = lsu_pkg::funct3_e'(f3);
        req.addr   = addr;
        req.w_data = w_data;
        issued++;
        while (!seen) begin
            @(posedge AXI_ACLK); // Outputs of the cycle just ending
            if (done) begin
                seen = 1'b1;
            end else if (cycles == TIMEOUT) begin
                $display("Timeout: %s got no done within %0d cycles", tag, TIMEOUT);
                abort_run();
            end else begin
                cycles++;
            end
        end
        if (op == OP_NONE && cycles != 0) begin
            $display("Request without read or write on %s took %0d cycles, expected done at once",
                     tag, cycles);
            abort_run();
        end
        if (op == OP_READ) begin
            check_data(r_data, exp_data, {tag, " load data"});
        end
        check_err(err, exp_err, {tag, " err"});
        @(negedge AXI_ACLK);
        if (done_count != issued) begin
            $display("Done pulses lost or doubled: %0d pulses for %0d requests after %s",
                     done_count, issued, tag);
            abort_run();
        end
    endtask

    // LD of every RAM word, compared with the reference model
    task automatic read_back_all(input string phase);
        lsu_pkg::addr_t addr;
        lsu_pkg::xlen_t exp_data;
        logic           exp_err;
        for (int wd = 0; wd < MEM_WORDS; wd++) begin
            addr = 32'(wd) << 3;
            model_access(OP_READ, 3'b011, addr, '0, exp_data, exp_err);
            run_req(OP_READ, 3'b011, addr, '0, exp_data, exp_err,
                    $sformatf("%s read-back of word %0d", phase, wd));
        end
    endtask

    initial begin
        logic [1:0]     op;
        logic [2:0]     f3;
        lsu_pkg::addr_t addr;
        lsu_pkg::xlen_t w_data;
        lsu_pkg::xlen_t exp_data;
        logic           exp_err;
        lsu_pkg::xlen_t model_data;
        logic           model_err;
        int unsigned    pick;
        int             n_file;

        AXI_ACLK    = 1'b0;
        AXI_ARESETN = 1'b0;
        req         = '0;
        issued      = 0;
        n_file      = 0;
        pick        = $urandom(32'h4007);
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;    // RAM clears at reset
        end
        for (int i = 0; i < FIELDS*MAX_CASES; i++) begin
            case_mem[i] = '1;        // End marker
        end
        $readmemh("testbench/lsu_cases.txt", case_mem);

        repeat (4) @(posedge AXI_ACLK);
        @(negedge AXI_ACLK);
        AXI_ARESETN = 1'b1;

        // Directed cases, each expected value checked against the model first
        while (n_file < MAX_CASES && case_mem[FIELDS*n_file] != '1) begin
            op       = case_mem[FIELDS*n_file][1:0];
            f3       = case_mem[FIELDS*n_file+1][2:0];
            addr     = case_mem[FIELDS*n_file+2][31:0];
            w_data   = case_mem[FIELDS*n_file+3];
            exp_data = case_mem[FIELDS*n_file+4];
            exp_err  = case_mem[FIELDS*n_file+5][0];
            model_access(op, f3, addr, w_data, model_data, model_err);
            if (model_err !== exp_err || (op == OP_READ && model_data !== exp_data)) begin
                $display("Case file entry %0d disagrees with the reference model", n_file + 1);
                abort_run();
            end
            run_req(op, f3, addr, w_data, exp_data, exp_err,
                    $sformatf("file case %0d", n_file + 1));
            n_file++;
        end
        read_back_all("file");

        // Back-to-back random aligned accesses, mostly in the first 8 words
        for (int n = 0; n < RAND_CASES; n++) begin
            pick = $urandom % 8;
            if (pick == 0) begin
                op = OP_NONE;
            end else if (pick < 5) begin
                op = OP_READ;
            end else begin
                op = OP_WRITE;
            end
            if (op == OP_READ) begin
                f3 = 3'($urandom % 7);
            end else begin
                f3 = 3'($urandom % 4);
            end
            addr = 32'($urandom % 64) & ~(access_size(f3) - 1);
            if (($urandom % 16) == 0) begin
                addr = addr + 32'h200;   // Past the end of the RAM
            end
            w_data = {$urandom, $urandom};
            model_access(op, f3, addr, w_data, model_data, model_err);
            run_req(op, f3, addr, w_data, model_data, model_err,
                    $sformatf("random access %0d", n));
        end
        read_back_all("random");

        req = '0;
        @(negedge AXI_ACLK);
        if (done_count != issued) begin
            $display("Extra done pulse after the last request: %0d pulses for %0d requests",
                     done_count, issued);
            abort_run();
        end
        if (n_file > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("No cases were read from testbench/lsu_cases.txt");
            abort_run();
        end
    end

endmodule

//--- testbench/lsu_assert.sv
`timescale 1ns/1ps

module lsu_assert (
    input logic                   AXI_ACLK,
    input logic                   AXI_ARESETN,
    input axi_lite_pkg::aw_chan_t aw,
    input logic                   aw_valid,
    input logic                   aw_ready,
    input axi_lite_pkg::w_chan_t  w,
    input logic                   w_valid,
    input logic                   w_ready,
    input logic                   b_valid,
    input logic                   b_ready,
    input axi_lite_pkg::ar_chan_t ar,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input logic                   r_valid,
    input logic                   r_ready,
    input logic                   finish
);

    // Valid stays up until its handshake
    aw_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        aw_valid && !aw_ready |=> aw_valid)
        else $error("AW valid dropped before AW ready");
    w_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        w_valid && !w_ready |=> w_valid)
        else $error("W valid dropped before W ready");
    ar_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        ar_valid && !ar_ready |=> ar_valid)
        else $error("AR valid dropped before AR ready");
    b_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        b_valid && !b_ready |=> b_valid)
        else $error("B valid dropped before B ready");
    r_hold: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        r_valid && !r_ready |=> r_valid)
        else $error("R valid dropped before R ready");

    // Payload frozen while the slave stalls
    aw_stable: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        aw_valid && !aw_ready |=> $stable(aw))
        else $error("AW payload changed while waiting");
    w_stable: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        w_valid && !w_ready |=> $stable(w))
        else $error("W payload changed while waiting");
    ar_stable: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        ar_valid && !ar_ready |=> $stable(ar))
        else $error("AR payload changed while waiting");

    finish_pulse: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        finish |=> !finish)
        else $error("finish high on two cycles in a row");

endmodule

bind lsu_axi_master lsu_assert i_lsu_assert (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_ARESETN(AXI_ARESETN),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .finish     (finish)
);

//--- hw/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem #(
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_CYCLES = 2
) (
    input  logic              AXI_ACLK,
    input  logic              AXI_ARESETN,
    input  lsu_pkg::lsu_req_t req,
    output logic              done,
    output lsu_pkg::xlen_t    r_data,
    output logic              err
);

    // AXI4-Lite between the LSU and the RAM
    axi_lite_pkg::aw_chan_t aw;
    axi_lite_pkg::w_chan_t  w;
    axi_lite_pkg::ar_chan_t ar;
    axi_lite_pkg::r_chan_t  r;
    axi_lite_pkg::resp_e    b_resp;
    logic                   aw_valid;
    logic                   aw_ready;
    logic                   w_valid;
    logic                   w_ready;
    logic                   b_valid;
    logic                   b_ready;
    logic                   ar_valid;
    logic                   ar_ready;
    logic                   r_valid;
    logic                   r_ready;

    lsu_axi_lite i_lsu_axi_lite (
        .AXI_ACLK   (AXI_ACLK),
        .AXI_ARESETN(AXI_ARESETN),
        .req        (req),
        .done       (done),
        .r_data     (r_data),
        .err        (err),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b_resp     (b_resp),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready)
    );

    axi_lite_ram #(
        .MEM_WORDS  (MEM_WORDS),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_axi_lite_ram (
        .AXI_ACLK   (AXI_ACLK),
        .AXI_ARESETN(AXI_ARESETN),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b_resp     (b_resp),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready)
    );

endmodule

//--- hw/axi_lite_ram.sv
`timescale 1ns/1ps

module axi_lite_ram #(
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_CYCLES = 2
) (
    input  logic                   AXI_ACLK,
    input  logic                   AXI_ARESETN,
    input  axi_lite_pkg::aw_chan_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_lite_pkg::w_chan_t  w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_lite_pkg::resp_e    b_resp,
    output logic                   b_valid,
    input  logic                   b_ready,
    input  axi_lite_pkg::ar_chan_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_lite_pkg::r_chan_t  r,
    output logic                   r_valid,
    input  logic                   r_ready
);

    localparam int IW    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CW    = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
    localparam int NCH   = 5;
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;
    localparam int CH_B  = 3;
    localparam int CH_R  = 4;

    lsu_pkg::xlen_t        mem [MEM_WORDS];
    lsu_pkg::addr_t        aw_addr_q;
    lsu_pkg::addr_t        ar_addr_q;
    axi_lite_pkg::w_chan_t w_q;
    logic                  aw_got;
    logic                  w_got;
    logic                  ar_got;
    logic                  aw_hit;
    logic                  ar_hit;
    logic [NCH-1:0]        pend;  // Channel waiting for its ready or valid
    logic [NCH-1:0]        fire;
    logic [NCH-1:0]        hs;
    logic [CW-1:0]         cnt [NCH];

    assign pend[CH_AW] = aw_valid && !aw_got;
    assign pend[CH_W]  = w_valid && !w_got;
    assign pend[CH_AR] = ar_valid && !ar_got;
    assign pend[CH_B]  = aw_got && w_got;  // Both halves of the write are in
    assign pend[CH_R]  = ar_got;

    assign hs[CH_AW] = aw_valid && aw_ready;
    assign hs[CH_W]  = w_valid && w_ready;
    assign hs[CH_AR] = ar_valid && ar_ready;
    assign hs[CH_B]  = b_valid && b_ready;
    assign hs[CH_R]  = r_valid && r_ready;

    // Same wait counter for every channel, parks at WAIT_CYCLES
    for (genvar i = 0; i < NCH; i++) begin : g_wait
        always_ff @(posedge AXI_ACLK) begin
            if (!AXI_ARESETN || !pend[i] || hs[i]) begin
                cnt[i] <= '0;
            end else if (cnt[i] != CW'(WAIT_CYCLES)) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
        assign fire[i] = pend[i] && (cnt[i] == CW'(WAIT_CYCLES));
    end

    assign aw_ready = fire[CH_AW];
    assign w_ready  = fire[CH_W];
    assign ar_ready = fire[CH_AR];
    assign b_valid  = fire[CH_B];   // Held since the counter parks
    assign r_valid  = fire[CH_R];

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            ar_got <= 1'b0;
        end else begin
            if (hs[CH_AW]) begin
                aw_got <= 1'b1;
            end else if (hs[CH_B]) begin
                aw_got <= 1'b0;
            end
            if (hs[CH_W]) begin
                w_got <= 1'b1;
            end else if (hs[CH_B]) begin
                w_got <= 1'b0;
            end
            if (hs[CH_AR]) begin
                ar_got <= 1'b1;
            end else if (hs[CH_R]) begin
                ar_got <= 1'b0;
            end
        end
    end

    always_ff @(posedge AXI_ACLK) begin
        if (hs[CH_AW]) aw_addr_q <= aw.addr;
        if (hs[CH_W])  w_q       <= w;
        if (hs[CH_AR]) ar_addr_q <= ar.addr;
    end

    // Word index is addr / 8
    assign aw_hit = {3'b000, aw_addr_q[31:3]} < 32'(MEM_WORDS);
    assign ar_hit = {3'b000, ar_addr_q[31:3]} < 32'(MEM_WORDS);

    // Write commits on the B handshake, out of range is dropped
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (hs[CH_B] && aw_hit) begin
            for (int b = 0; b < 8; b++) begin
                if (w_q.strb[b]) begin
                    mem[aw_addr_q[3 +: IW]][8*b +: 8] <= w_q.data[8*b +: 8];
                end
            end
        end
    end

    assign b_resp = aw_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
    assign r.data = ar_hit ? mem[ar_addr_q[3 +: IW]] : '0;
    assign r.resp = ar_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;

endmodule

//--- hw/lsu_axi_lite.sv
`timescale 1ns/1ps

module lsu_axi_lite (
    input  logic                   AXI_ACLK,
    input  logic                   AXI_ARESETN,
    input  lsu_pkg::lsu_req_t      req,
    output logic                   done,
    output lsu_pkg::xlen_t         r_data,
    output logic                   err,
    output axi_lite_pkg::aw_chan_t aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_lite_pkg::w_chan_t  w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_lite_pkg::resp_e    b_resp,
    input  logic                   b_valid,
    output logic                   b_ready,
    output axi_lite_pkg::ar_chan_t ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  axi_lite_pkg::r_chan_t  r,
    input  logic                   r_valid,
    output logic                   r_ready
);

    logic                start_read;
    logic                start_write;
    logic                no_op;
    logic                finish;
    lsu_pkg::xlen_t      store_word;
    lsu_pkg::xlen_t      rd_word;
    axi_lite_pkg::strb_t strb;
    axi_lite_pkg::resp_e resp;

    assign start_read  = req.valid && req.r_en;
    assign start_write = req.valid && req.w_en;
    assign no_op       = req.valid && !req.r_en && !req.w_en; // Completes at once

    assign done = finish || no_op;
    // rd_word and resp are the captured bus values, request fields are held until done
    assign err  = finish && (resp == axi_lite_pkg::SLVERR);

    lsu_data_align i_lsu_data_align (
        .funct3    (req.funct3),
        .addr      (req.addr),
        .w_data    (req.w_data),
        .rd_word   (rd_word),
        .load_data (r_data),
        .store_word(store_word),
        .strb      (strb)
    );

    lsu_axi_master i_lsu_axi_master (
        .AXI_ACLK   (AXI_ACLK),
        .AXI_ARESETN(AXI_ARESETN),
        .start_read (start_read),
        .start_write(start_write),
        .addr       (req.addr),
        .store_word (store_word),
        .strb       (strb),
        .finish     (finish),
        .rd_word    (rd_word),
        .resp       (resp),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b_resp     (b_resp),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready)
    );

endmodule

//--- hw/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master (
    input  logic                   AXI_ACLK,
    input  logic                   AXI_ARESETN,
    input  logic                   start_read,
    input  logic                   start_write,
    input  lsu_pkg::addr_t         addr,
    input  lsu_pkg::xlen_t         store_word,
    input  axi_lite_pkg::strb_t    strb,
    output logic                   finish,
    output lsu_pkg::xlen_t         rd_word,
    output axi_lite_pkg::resp_e    resp,
    output axi_lite_pkg::aw_chan_t aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_lite_pkg::w_chan_t  w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_lite_pkg::resp_e    b_resp,
    input  logic                   b_valid,
    output logic                   b_ready,
    output axi_lite_pkg::ar_chan_t ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  axi_lite_pkg::r_chan_t  r,
    input  logic                   r_valid,
    output logic                   r_ready
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_BOTH, // AW and W both outstanding
        WAIT_W,     // AW taken, W still pending
        WAIT_AW,    // W taken, AW still pending
        WAIT_B,
        READ_ADDR,
        WAIT_R,
        DONE
    } state_e;

    state_e              state;
    state_e              state_nxt;
    lsu_pkg::addr_t      addr_q;
    lsu_pkg::xlen_t      data_q;
    axi_lite_pkg::strb_t strb_q;

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_write) begin
                    state_nxt = WRITE_BOTH;
                end else if (start_read) begin
                    state_nxt = READ_ADDR;
                end
            end
            WRITE_BOTH: begin
                if (aw_ready && w_ready) begin
                    state_nxt = WAIT_B;
                end else if (aw_ready) begin
                    state_nxt = WAIT_W;
                end else if (w_ready) begin
                    state_nxt = WAIT_AW;
                end
            end
            WAIT_W:    if (w_ready) state_nxt = WAIT_B;
            WAIT_AW:   if (aw_ready) state_nxt = WAIT_B;
            WAIT_B:    if (b_valid) state_nxt = DONE;
            READ_ADDR: if (ar_ready) state_nxt = WAIT_R;
            WAIT_R:    if (r_valid) state_nxt = DONE;
            default:   state_nxt = IDLE; // DONE lasts one cycle
        endcase
    end

    // Request payload frozen for the whole transaction
    always_ff @(posedge AXI_ACLK) begin
        if (state == IDLE && (start_write || start_read)) begin
            addr_q <= addr;
            data_q <= store_word;
            strb_q <= strb;
        end
        if (b_valid && b_ready) begin
            resp <= b_resp;
        end
        if (r_valid && r_ready) begin
            rd_word <= r.data;
            resp    <= r.resp;
        end
    end

    // Moore outputs
    assign aw_valid = (state == WRITE_BOTH) || (state == WAIT_AW);
    assign w_valid  = (state == WRITE_BOTH) || (state == WAIT_W);
    assign b_ready  = (state == WAIT_B);
    assign ar_valid = (state == READ_ADDR);
    assign r_ready  = (state == WAIT_R);
    assign finish   = (state == DONE);

    assign aw.addr = addr_q;
    assign aw.prot = '0;     // Unprivileged, secure, data
    assign w.data  = data_q;
    assign w.strb  = strb_q;
    assign ar.addr = addr_q;
    assign ar.prot = '0;

endmodule

//--- hw/lsu_data_align.sv
`timescale 1ns/1ps

module lsu_data_align (
    input  lsu_pkg::funct3_e    funct3,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::xlen_t      w_data,
    input  lsu_pkg::xlen_t      rd_word,
    output lsu_pkg::xlen_t      load_data,
    output lsu_pkg::xlen_t      store_word,
    output axi_lite_pkg::strb_t strb
);

    lsu_pkg::offset_t offset;
    lsu_pkg::xlen_t   rd_shift;
    logic [7:0]       rd_b;
    logic [15:0]      rd_h;
    logic [31:0]      rd_w;
    logic             fit_h;
    logic             fit_w;
    logic             fit_d;

    assign offset = addr[2:0];

    // Access must stay inside the 8-byte lane
    assign fit_h = (offset != 3'd7);
    assign fit_w = (offset <= 3'd4);
    assign fit_d = (offset == 3'd0);

    // Selected field moved down to bit 0
    assign rd_shift = rd_word >> {offset, 3'b000};
    assign rd_b     = rd_shift[7:0];
    assign rd_h     = fit_h ? rd_shift[15:0] : 16'h0000;
    assign rd_w     = fit_w ? rd_shift[31:0] : 32'h0000_0000;

    always_comb begin
        case (funct3)
            lsu_pkg::LB:  load_data = {{56{rd_b[7]}}, rd_b};
            lsu_pkg::LH:  load_data = {{48{rd_h[15]}}, rd_h};
            lsu_pkg::LW:  load_data = {{32{rd_w[31]}}, rd_w};
            lsu_pkg::LBU: load_data = {56'd0, rd_b};
            lsu_pkg::LHU: load_data = {48'd0, rd_h};
            lsu_pkg::LWU: load_data = {32'd0, rd_w};
            lsu_pkg::LD:  load_data = fit_d ? rd_word : '0;
            default:      load_data = '0;
        endcase
    end

    // Low bytes of the store value land at the offset
    assign store_word = w_data << {offset, 3'b000};

    // Crossing stores get no strobe bits at all
    always_comb begin
        case (funct3)
            lsu_pkg::SB: strb = 8'h01 << offset;
            lsu_pkg::SH: strb = fit_h ? (8'h03 << offset) : 8'h00;
            lsu_pkg::SW: strb = fit_w ? (8'h0f << offset) : 8'h00;
            lsu_pkg::SD: strb = fit_d ? 8'hff : 8'h00;
            default:     strb = 8'h00;
        endcase
    end

endmodule

//--- hw/axi_lite_pkg.sv
package axi_lite_pkg;

    typedef logic [7:0] strb_t; // One bit per byte of the 64-bit bus
    typedef logic [2:0] prot_t;

    // Only the two responses this system produces
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Write address channel
    typedef struct packed {
        lsu_pkg::addr_t addr;
        prot_t          prot;
    } aw_chan_t;

    // Write data channel
    typedef struct packed {
        lsu_pkg::xlen_t data;
        strb_t          strb;
    } w_chan_t;

    // Read address channel
    typedef struct packed {
        lsu_pkg::addr_t addr;
        prot_t          prot;
    } ar_chan_t;

    // Read data channel
    typedef struct packed {
        lsu_pkg::xlen_t data;
        resp_e          resp;
    } r_chan_t;

endpackage

//--- hw/lsu_pkg.sv
package lsu_pkg;

    // Core-side widths
    typedef logic [63:0] xlen_t;   // One data word, also one 8-byte lane
    typedef logic [31:0] addr_t;   // Byte address
    typedef logic [2:0]  offset_t; // Byte offset inside the lane

    // Load encodings of funct3
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } funct3_e;

    // Stores reuse encodings 0 to 3
    localparam funct3_e SB = funct3_e'(3'b000);
    localparam funct3_e SH = funct3_e'(3'b001);
    localparam funct3_e SW = funct3_e'(3'b010);
    localparam funct3_e SD = funct3_e'(3'b011);

    // Level request from the core, held until done
    typedef struct packed {
        logic    valid;
        logic    r_en;
        logic    w_en;
        funct3_e funct3;
        addr_t   addr;
        xlen_t   w_data;
    } lsu_req_t;

endpackage
